// ==== src/mips_cfg.svh ====
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// Data and address width of the MIPS32 integer datapath
`define XLEN 32

`define REG_COUNT 32
`define REG_ADDR_W 5

// First instruction address after reset
`define RESET_PC 32'h0000_0000

`endif

// ==== src/mipsPkg.sv ====
`include "mips_cfg.svh"

package mipsPkg;

	typedef logic [`XLEN-1:0] word_t;
	typedef logic [`XLEN-1:0] addr_t;
	typedef logic [`REG_ADDR_W-1:0] regAddr_t;

	// Primary opcodes in instr[31:26]
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'h00,
		OP_J       = 6'h02,
		OP_BEQ     = 6'h04,
		OP_BNE     = 6'h05,
		OP_ADDIU   = 6'h09,
		OP_ORI     = 6'h0d,
		OP_LUI     = 6'h0f,
		OP_LW      = 6'h23,
		OP_SW      = 6'h2b
	} opcode_t;

	// Function codes of SPECIAL in instr[5:0]
	typedef enum logic [5:0] {
		FN_SLL  = 6'h00,
		FN_ADDU = 6'h21,
		FN_SUBU = 6'h23,
		FN_AND  = 6'h24,
		FN_OR   = 6'h25,
		FN_XOR  = 6'h26,
		FN_SLT  = 6'h2a
	} funct_t;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLL, ALU_LUI
	} aluOp_t;

	typedef enum logic [1:0] {
		FWD_REG, FWD_MEM, FWD_WB
	} fwdSel_t;

endpackage

// ==== src/regFile.sv ====
`timescale 1ns/1ps
`include "mips_cfg.svh"

module regFile
	import mipsPkg::*;
(
	input  logic     clk,
	input  logic     rstN_i,
	input  regAddr_t raddrA_i,
	input  regAddr_t raddrB_i,
	output word_t    rdataA_o,
	output word_t    rdataB_o,
	input  logic     we_i,
	input  regAddr_t waddr_i,
	input  word_t    wdata_i
);

	word_t regs [`REG_COUNT];
	logic  wrValid;

	assign wrValid = we_i && waddr_i != '0;

	always_ff @(posedge clk or negedge rstN_i) begin
		if (!rstN_i) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wrValid) begin
			regs[waddr_i] <= wdata_i;
		end
	end

	// A write in this cycle is already visible to decode
	assign rdataA_o = (wrValid && waddr_i == raddrA_i) ? wdata_i : regs[raddrA_i];
	assign rdataB_o = (wrValid && waddr_i == raddrB_i) ? wdata_i : regs[raddrB_i];

	zeroRegReadsZero: assert property (@(posedge clk) disable iff (!rstN_i)
		(raddrA_i != '0 || rdataA_o == '0) && (raddrB_i != '0 || rdataB_o == '0));

endmodule

// ==== src/fetchStage.sv ====
`timescale 1ns/1ps
`include "mips_cfg.svh"

module fetchStage
	import mipsPkg::*;
(
	input  logic  clk,
	input  logic  rstN_i,
	input  logic  stall_i,
	input  logic  branchTaken_i,
	input  addr_t branchTarget_i,
	output addr_t instSramAddr_o,
	input  word_t instSramRdata_i,
	output word_t instrD_o,
	output addr_t pcD_o
);

	// Address of the instruction now on the SRAM read port
	addr_t pcF;
	logic  fetchValid;

	always_comb begin
		if (stall_i) begin
			instSramAddr_o = pcF;
		end else if (branchTaken_i) begin
			instSramAddr_o = branchTarget_i;
		end else begin
			instSramAddr_o = pcF + 32'd4;
		end
	end

	always_ff @(posedge clk or negedge rstN_i) begin
		if (!rstN_i) begin
			pcF <= `RESET_PC - 32'd4;
			fetchValid <= 1'b0;
		end else begin
			pcF <= instSramAddr_o;
			fetchValid <= 1'b1;
		end
	end

	// Read data in the first cycle out of reset belongs to no fetch
	always_ff @(posedge clk or negedge rstN_i) begin
		if (!rstN_i) begin
			instrD_o <= '0;
		end else if (!stall_i) begin
			instrD_o <= fetchValid ? instSramRdata_i : '0;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall_i) begin
			pcD_o <= pcF;
		end
	end

endmodule

// ==== src/decodeStage.sv ====
`timescale 1ns/1ps
`include "mips_cfg.svh"

module decodeStage
	import mipsPkg::*;
(
	input  logic     clk,
	input  logic     rstN_i,
	input  logic     stall_i,
	input  logic     bubble_i,
	input  word_t    instrD_i,
	input  addr_t    pcD_i,
	output regAddr_t rsAddr_o,
	output regAddr_t rtAddr_o,
	input  word_t    rsData_i,
	input  word_t    rtData_i,
	input  fwdSel_t  fwdA_i,
	input  fwdSel_t  fwdB_i,
	input  word_t    resultM_i,
	output logic     branchD_o,
	output logic     branchTaken_o,
	output addr_t    branchTarget_o,
	output aluOp_t   aluOpE_o,
	output word_t    opAE_o,
	output word_t    opBE_o,
	output word_t    immE_o,
	output logic     useImmE_o,
	output logic     memReadE_o,
	output logic     memWriteE_o,
	output logic     regWriteE_o,
	output regAddr_t rsE_o,
	output regAddr_t rtE_o,
	output regAddr_t destE_o,
	output addr_t    pcE_o
);

	aluOp_t   aluOp;
	word_t    imm;
	word_t    opA;
	word_t    opB;
	addr_t    pcPlus4;
	regAddr_t dest;
	logic     useImm;
	logic     memRead;
	logic     memWrite;
	logic     regWrite;
	logic     destIsRd;
	logic     isBeq;
	logic     isBne;
	logic     isJump;

	assign rsAddr_o = instrD_i[25:21];
	assign rtAddr_o = instrD_i[20:16];

	always_comb begin
		aluOp = ALU_ADD;
		imm = {{16{instrD_i[15]}}, instrD_i[15:0]};
		useImm = 1'b1;
		memRead = 1'b0;
		memWrite = 1'b0;
		regWrite = 1'b0;
		destIsRd = 1'b0;
		isBeq = 1'b0;
		isBne = 1'b0;
		isJump = 1'b0;
		case (opcode_t'(instrD_i[31:26]))
			OP_SPECIAL: begin
				// Shift amount rides in the immediate field
				imm = {27'b0, instrD_i[10:6]};
				useImm = 1'b0;
				destIsRd = 1'b1;
				regWrite = 1'b1;
				case (funct_t'(instrD_i[5:0]))
					FN_ADDU: aluOp = ALU_ADD;
					FN_SUBU: aluOp = ALU_SUB;
					FN_AND:  aluOp = ALU_AND;
					FN_OR:   aluOp = ALU_OR;
					FN_XOR:  aluOp = ALU_XOR;
					FN_SLT:  aluOp = ALU_SLT;
					FN_SLL:  aluOp = ALU_SLL;
					default: regWrite = 1'b0;
				endcase
			end
			OP_ADDIU: regWrite = 1'b1;
			OP_ORI: begin
				aluOp = ALU_OR;
				imm = {16'b0, instrD_i[15:0]};
				regWrite = 1'b1;
			end
			OP_LUI: begin
				aluOp = ALU_LUI;
				regWrite = 1'b1;
			end
			OP_LW: begin
				memRead = 1'b1;
				regWrite = 1'b1;
			end
			OP_SW:  memWrite = 1'b1;
			OP_BEQ: isBeq = 1'b1;
			OP_BNE: isBne = 1'b1;
			OP_J:   isJump = 1'b1;
			default: ;
		endcase
	end

	assign dest = !regWrite ? '0 : destIsRd ? instrD_i[15:11] : rtAddr_o;

	// The comparator takes writeback results from the register file bypass
	assign opA = (fwdA_i == FWD_MEM) ? resultM_i : rsData_i;
	assign opB = (fwdB_i == FWD_MEM) ? resultM_i : rtData_i;

	assign pcPlus4 = pcD_i + 32'd4;
	assign branchD_o = isBeq | isBne;
	assign branchTaken_o = !stall_i &&
		(isJump || (isBeq && opA == opB) || (isBne && opA != opB));
	assign branchTarget_o = isJump ? {pcPlus4[31:28], instrD_i[25:0], 2'b00}
		: pcPlus4 + {imm[29:0], 2'b00};

	always_ff @(posedge clk or negedge rstN_i) begin
		if (!rstN_i) begin
			memReadE_o <= 1'b0;
			memWriteE_o <= 1'b0;
			regWriteE_o <= 1'b0;
			destE_o <= '0;
		end else begin
			memReadE_o <= memRead & !bubble_i;
			memWriteE_o <= memWrite & !bubble_i;
			regWriteE_o <= regWrite & !bubble_i;
			destE_o <= bubble_i ? '0 : dest;
		end
	end

	always_ff @(posedge clk) begin
		aluOpE_o <= aluOp;
		opAE_o <= opA;
		opBE_o <= opB;
		immE_o <= imm;
		useImmE_o <= useImm;
		rsE_o <= rsAddr_o;
		rtE_o <= rtAddr_o;
		pcE_o <= pcD_i;
	end

	compareNoWbSelect: assert property (@(posedge clk) disable iff (!rstN_i)
		fwdA_i != FWD_WB && fwdB_i != FWD_WB);

endmodule

// ==== src/executeStage.sv ====
`timescale 1ns/1ps
`include "mips_cfg.svh"

module executeStage
	import mipsPkg::*;
(
	input  logic       clk,
	input  logic       rstN_i,
	input  aluOp_t     aluOpE_i,
	input  word_t      opAE_i,
	input  word_t      opBE_i,
	input  word_t      immE_i,
	input  logic       useImmE_i,
	input  logic       memReadE_i,
	input  logic       memWriteE_i,
	input  logic       regWriteE_i,
	input  regAddr_t   destE_i,
	input  addr_t      pcE_i,
	input  fwdSel_t    fwdA_i,
	input  fwdSel_t    fwdB_i,
	input  word_t      resultW_i,
	output regAddr_t   destE_o,
	output logic       regWriteE_o,
	output logic       memReadE_o,
	output logic       dataSramEn_o,
	output logic [3:0] dataSramWen_o,
	output addr_t      dataSramAddr_o,
	output word_t      dataSramWdata_o,
	output word_t      resultM_o,
	output regAddr_t   destM_o,
	output logic       regWriteM_o,
	output logic       memReadM_o,
	output addr_t      pcM_o
);

	word_t srcA;
	word_t srcB;
	word_t aluB;
	word_t aluOut;

	function automatic word_t fwdMux(fwdSel_t sel, word_t regVal, word_t memVal, word_t wbVal);
		case (sel)
			FWD_MEM: return memVal;
			FWD_WB:  return wbVal;
			default: return regVal;
		endcase
	endfunction

	assign srcA = fwdMux(fwdA_i, opAE_i, resultM_o, resultW_i);
	assign srcB = fwdMux(fwdB_i, opBE_i, resultM_o, resultW_i);
	assign aluB = useImmE_i ? immE_i : srcB;

	always_comb begin
		case (aluOpE_i)
			ALU_SUB: aluOut = srcA - aluB;
			ALU_AND: aluOut = srcA & aluB;
			ALU_OR:  aluOut = srcA | aluB;
			ALU_XOR: aluOut = srcA ^ aluB;
			ALU_SLT: aluOut = {31'b0, $signed(srcA) < $signed(aluB)};
			ALU_SLL: aluOut = srcB << immE_i[4:0];
			ALU_LUI: aluOut = {aluB[15:0], 16'b0};
			default: aluOut = srcA + aluB;
		endcase
	end

	// Whole-word accesses only
	assign dataSramEn_o = memReadE_i | memWriteE_i;
	assign dataSramWen_o = {4{memWriteE_i}};
	assign dataSramAddr_o = aluOut;
	assign dataSramWdata_o = srcB;

	assign destE_o = destE_i;
	assign regWriteE_o = regWriteE_i;
	assign memReadE_o = memReadE_i;

	always_ff @(posedge clk or negedge rstN_i) begin
		if (!rstN_i) begin
			regWriteM_o <= 1'b0;
			memReadM_o <= 1'b0;
			destM_o <= '0;
		end else begin
			regWriteM_o <= regWriteE_i;
			memReadM_o <= memReadE_i;
			destM_o <= destE_i;
		end
	end

	always_ff @(posedge clk) begin
		resultM_o <= aluOut;
		pcM_o <= pcE_i;
	end

	noReadAndWrite: assert property (@(posedge clk) disable iff (!rstN_i)
		!(memReadE_i && memWriteE_i));

endmodule

// ==== src/memoryStage.sv ====
`timescale 1ns/1ps
`include "mips_cfg.svh"

module memoryStage
	import mipsPkg::*;
(
	input  logic       clk,
	input  logic       rstN_i,
	input  word_t      resultM_i,
	input  regAddr_t   destM_i,
	input  logic       regWriteM_i,
	input  logic       memReadM_i,
	input  addr_t      pcM_i,
	input  word_t      dataSramRdata_i,
	output logic       rfWe_o,
	output regAddr_t   rfWaddr_o,
	output word_t      rfWdata_o,
	output addr_t      debugWbPc_o,
	output logic [3:0] debugWbRfWen_o,
	output regAddr_t   debugWbRfWnum_o,
	output word_t      debugWbRfWdata_o
);

	word_t wbData;

	// Load data arrives this cycle from the request made in execute
	assign wbData = memReadM_i ? dataSramRdata_i : resultM_i;

	always_ff @(posedge clk or negedge rstN_i) begin
		if (!rstN_i) begin
			rfWe_o <= 1'b0;
		end else begin
			rfWe_o <= regWriteM_i && destM_i != '0;
		end
	end

	always_ff @(posedge clk) begin
		rfWaddr_o <= destM_i;
		rfWdata_o <= wbData;
		debugWbPc_o <= pcM_i;
	end

	assign debugWbRfWen_o = {4{rfWe_o}};
	assign debugWbRfWnum_o = rfWaddr_o;
	assign debugWbRfWdata_o = rfWdata_o;

endmodule

// ==== src/hazardUnit.sv ====
`timescale 1ns/1ps
`include "mips_cfg.svh"

module hazardUnit
	import mipsPkg::*;
(
	input  regAddr_t rsD_i,
	input  regAddr_t rtD_i,
	input  logic     branchD_i,
	input  regAddr_t rsE_i,
	input  regAddr_t rtE_i,
	input  regAddr_t destE_i,
	input  logic     regWriteE_i,
	input  logic     memReadE_i,
	input  regAddr_t destM_i,
	input  logic     regWriteM_i,
	input  logic     memReadM_i,
	input  regAddr_t destW_i,
	input  logic     regWriteW_i,
	output logic     stallF_o,
	output logic     stallD_o,
	output logic     bubbleE_o,
	output fwdSel_t  fwdAD_o,
	output fwdSel_t  fwdBD_o,
	output fwdSel_t  fwdAE_o,
	output fwdSel_t  fwdBE_o
);

	logic loadUse;
	logic branchWait;
	logic stall;

	// Register zero never produces a dependence
	function automatic logic hit(regAddr_t dest, logic we, regAddr_t src);
		return we && dest != '0 && dest == src;
	endfunction

	assign fwdAD_o = hit(destM_i, regWriteM_i, rsD_i) ? FWD_MEM : FWD_REG;
	assign fwdBD_o = hit(destM_i, regWriteM_i, rtD_i) ? FWD_MEM : FWD_REG;

	assign fwdAE_o = hit(destM_i, regWriteM_i, rsE_i) ? FWD_MEM :
		hit(destW_i, regWriteW_i, rsE_i) ? FWD_WB : FWD_REG;
	assign fwdBE_o = hit(destM_i, regWriteM_i, rtE_i) ? FWD_MEM :
		hit(destW_i, regWriteW_i, rtE_i) ? FWD_WB : FWD_REG;

	assign loadUse = hit(destE_i, memReadE_i, rsD_i) || hit(destE_i, memReadE_i, rtD_i);

	// The comparator only sees results that have reached memory as ALU values
	assign branchWait = branchD_i &&
		(hit(destE_i, regWriteE_i, rsD_i) || hit(destE_i, regWriteE_i, rtD_i) ||
		hit(destM_i, memReadM_i, rsD_i) || hit(destM_i, memReadM_i, rtD_i));

	assign stall = loadUse || branchWait;
	assign stallF_o = stall;
	assign stallD_o = stall;
	assign bubbleE_o = stall;

endmodule

// ==== src/mycpuTop.sv ====
`timescale 1ns/1ps
`include "mips_cfg.svh"

module mycpuTop
	import mipsPkg::*;
(
	input  logic       clk,
	input  logic       rstN_i,
	output addr_t      instSramAddr_o,
	input  word_t      instSramRdata_i,
	output logic       dataSramEn_o,
	output logic [3:0] dataSramWen_o,
	output addr_t      dataSramAddr_o,
	output word_t      dataSramWdata_o,
	input  word_t      dataSramRdata_i,
	output addr_t      debugWbPc_o,
	output logic [3:0] debugWbRfWen_o,
	output regAddr_t   debugWbRfWnum_o,
	output word_t      debugWbRfWdata_o
);

	word_t    instrD;
	addr_t    pcD;
	logic     branchD;
	logic     branchTaken;
	addr_t    branchTarget;
	regAddr_t rsD;
	regAddr_t rtD;
	word_t    rsDataD;
	word_t    rtDataD;
	logic     stallF;
	logic     stallD;
	logic     bubbleE;
	fwdSel_t  fwdAD;
	fwdSel_t  fwdBD;
	fwdSel_t  fwdAE;
	fwdSel_t  fwdBE;
	aluOp_t   aluOpE;
	word_t    opAE;
	word_t    opBE;
	word_t    immE;
	logic     useImmE;
	logic     memReadE;
	logic     memWriteE;
	logic     regWriteE;
	regAddr_t rsE;
	regAddr_t rtE;
	regAddr_t destE;
	addr_t    pcE;
	regAddr_t hzDestE;
	logic     hzRegWriteE;
	logic     hzMemReadE;
	word_t    resultM;
	regAddr_t destM;
	logic     regWriteM;
	logic     memReadM;
	addr_t    pcM;
	logic     rfWe;
	regAddr_t rfWaddr;
	word_t    rfWdata;

	fetchStage fetch (
		.clk(clk), .rstN_i(rstN_i), .stall_i(stallF),
		.branchTaken_i(branchTaken), .branchTarget_i(branchTarget),
		.instSramAddr_o(instSramAddr_o), .instSramRdata_i(instSramRdata_i),
		.instrD_o(instrD), .pcD_o(pcD)
	);

	regFile regs (
		.clk(clk), .rstN_i(rstN_i),
		.raddrA_i(rsD), .raddrB_i(rtD), .rdataA_o(rsDataD), .rdataB_o(rtDataD),
		.we_i(rfWe), .waddr_i(rfWaddr), .wdata_i(rfWdata)
	);

	decodeStage decode (
		.clk(clk), .rstN_i(rstN_i), .stall_i(stallD), .bubble_i(bubbleE),
		.instrD_i(instrD), .pcD_i(pcD),
		.rsAddr_o(rsD), .rtAddr_o(rtD), .rsData_i(rsDataD), .rtData_i(rtDataD),
		.fwdA_i(fwdAD), .fwdB_i(fwdBD), .resultM_i(resultM),
		.branchD_o(branchD), .branchTaken_o(branchTaken), .branchTarget_o(branchTarget),
		.aluOpE_o(aluOpE), .opAE_o(opAE), .opBE_o(opBE), .immE_o(immE),
		.useImmE_o(useImmE), .memReadE_o(memReadE), .memWriteE_o(memWriteE),
		.regWriteE_o(regWriteE), .rsE_o(rsE), .rtE_o(rtE), .destE_o(destE), .pcE_o(pcE)
	);

	executeStage execute (
		.clk(clk), .rstN_i(rstN_i),
		.aluOpE_i(aluOpE), .opAE_i(opAE), .opBE_i(opBE), .immE_i(immE),
		.useImmE_i(useImmE), .memReadE_i(memReadE), .memWriteE_i(memWriteE),
		.regWriteE_i(regWriteE), .destE_i(destE), .pcE_i(pcE),
		.fwdA_i(fwdAE), .fwdB_i(fwdBE), .resultW_i(rfWdata),
		.destE_o(hzDestE), .regWriteE_o(hzRegWriteE), .memReadE_o(hzMemReadE),
		.dataSramEn_o(dataSramEn_o), .dataSramWen_o(dataSramWen_o),
		.dataSramAddr_o(dataSramAddr_o), .dataSramWdata_o(dataSramWdata_o),
		.resultM_o(resultM), .destM_o(destM), .regWriteM_o(regWriteM),
		.memReadM_o(memReadM), .pcM_o(pcM)
	);

	memoryStage memory (
		.clk(clk), .rstN_i(rstN_i),
		.resultM_i(resultM), .destM_i(destM), .regWriteM_i(regWriteM),
		.memReadM_i(memReadM), .pcM_i(pcM), .dataSramRdata_i(dataSramRdata_i),
		.rfWe_o(rfWe), .rfWaddr_o(rfWaddr), .rfWdata_o(rfWdata),
		.debugWbPc_o(debugWbPc_o), .debugWbRfWen_o(debugWbRfWen_o),
		.debugWbRfWnum_o(debugWbRfWnum_o), .debugWbRfWdata_o(debugWbRfWdata_o)
	);

	hazardUnit hazard (
		.rsD_i(rsD), .rtD_i(rtD), .branchD_i(branchD),
		.rsE_i(rsE), .rtE_i(rtE), .destE_i(hzDestE),
		.regWriteE_i(hzRegWriteE), .memReadE_i(hzMemReadE),
		.destM_i(destM), .regWriteM_i(regWriteM), .memReadM_i(memReadM),
		.destW_i(rfWaddr), .regWriteW_i(rfWe),
		.stallF_o(stallF), .stallD_o(stallD), .bubbleE_o(bubbleE),
		.fwdAD_o(fwdAD), .fwdBD_o(fwdBD), .fwdAE_o(fwdAE), .fwdBE_o(fwdBE)
	);

endmodule

// ==== sim/tbMemory.sv ====
`timescale 1ns/1ps

module tbMemory
	import mipsPkg::*;
(
	input  logic       clk,
	input  addr_t      instSramAddr_i,
	output word_t      instSramRdata_o,
	input  logic       dataSramEn_i,
	input  logic [3:0] dataSramWen_i,
	input  addr_t      dataSramAddr_i,
	input  word_t      dataSramWdata_i,
	output word_t      dataSramRdata_o,
	output logic       memFetched_o
);

	word_t imem [256];
	word_t dmem [256];
	int    segEnd [5];
	int    fill;
	word_t instRdata = '0;
	word_t dataRdata = '0;
	logic  memFetched = 1'b0;

	assign instSramRdata_o = instRdata;
	assign dataSramRdata_o = dataRdata;
	assign memFetched_o = memFetched;

	// Both SRAMs answer one cycle after the address and stores write whole words
	always @(posedge clk) begin
		instRdata <= imem[instSramAddr_i[9:2]];
		if (imem[instSramAddr_i[9:2]][31:26] inside {OP_LW, OP_SW}) begin
			memFetched <= 1'b1;
		end
		if (dataSramEn_i) begin
			dataRdata <= dmem[dataSramAddr_i[9:2]];
			if (dataSramWen_i != 4'h0) begin
				dmem[dataSramAddr_i[9:2]] <= dataSramWdata_i;
			end
		end
	end

	function automatic word_t rType(funct_t fn, regAddr_t rs, regAddr_t rt, regAddr_t rd,
		logic [4:0] sa);
		return {6'h00, rs, rt, rd, sa, fn};
	endfunction

	function automatic word_t iType(opcode_t op, regAddr_t rs, regAddr_t rt, logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t aluInstr(regAddr_t d, regAddr_t a);
		regAddr_t b;
		logic [15:0] imm;
		b = regAddr_t'($urandom % 16);
		imm = 16'($urandom);
		case ($urandom % 10)
			0: return rType(FN_ADDU, a, b, d, 0);
			1: return rType(FN_SUBU, a, b, d, 0);
			2: return rType(FN_AND, a, b, d, 0);
			3: return rType(FN_OR, a, b, d, 0);
			4: return rType(FN_XOR, a, b, d, 0);
			5: return rType(FN_SLT, a, b, d, 0);
			6: return rType(FN_SLL, 0, a, d, imm[4:0]);
			7: return iType(OP_ADDIU, a, d, imm);
			8: return iType(OP_ORI, a, d, imm);
			default: return iType(OP_LUI, 0, d, imm);
		endcase
	endfunction

	task automatic emit(word_t w);
		imem[fill] = w;
		fill++;
	endtask

	task automatic buildProgram();
		regAddr_t d;
		regAddr_t r;
		regAddr_t prev;
		opcode_t  brOp;
		int       off;
		fill = 0;
		for (int i = 0; i < 256; i++) begin
			imem[i] = '0;
			dmem[i] = 32'hc0de_0000 ^ (i << 2);
		end
		// Every source register gets a random value before it is read
		for (int i = 1; i < 16; i++) begin
			emit(iType(OP_LUI, 0, regAddr_t'(i), 16'($urandom)));
			emit(iType(OP_ORI, regAddr_t'(i), regAddr_t'(i), 16'($urandom)));
		end
		segEnd[0] = fill * 4;
		prev = 1;
		repeat (40) begin
			d = regAddr_t'(1 + $urandom % 15);
			emit(aluInstr(d, ($urandom % 2) ? prev : regAddr_t'($urandom % 16)));
			prev = d;
		end
		segEnd[1] = fill * 4;
		repeat (6) begin
			off = ($urandom % 256) * 4;
			d = regAddr_t'(1 + $urandom % 15);
			r = regAddr_t'(1 + $urandom % 15);
			emit(iType(OP_SW, 0, prev, 16'(off)));
			emit(iType(OP_LW, 0, d, 16'(off)));
			emit(rType(FN_ADDU, d, regAddr_t'($urandom % 16), r, 0));
			prev = r;
		end
		segEnd[2] = fill * 4;
		// Each branch reads the ALU result right before it and skips one instruction
		repeat (8) begin
			d = regAddr_t'(1 + $urandom % 15);
			emit(rType(FN_ADDU, regAddr_t'(1 + $urandom % 15), regAddr_t'($urandom % 16), d, 0));
			r = ($urandom % 2) ? d : regAddr_t'(1 + $urandom % 15);
			if ($urandom % 2) begin
				brOp = OP_BEQ;
			end else begin
				brOp = OP_BNE;
			end
			emit(iType(brOp, d, r, 16'd2));
			emit(aluInstr(regAddr_t'(1 + $urandom % 15), d));
			emit(aluInstr(regAddr_t'(1 + $urandom % 15), d));
		end
		segEnd[3] = fill * 4;
		emit(iType(OP_ADDIU, 1, 0, 16'($urandom)));
		emit(rType(FN_ADDU, 2, 3, 0, 0));
		emit({OP_J, 26'(fill + 3)});
		emit(iType(OP_ADDIU, 0, 4, 16'h0040));
		emit(iType(OP_ORI, 5, 5, 16'hffff));
		emit(rType(FN_ADDU, 0, 4, 6, 0));
		segEnd[4] = fill * 4;
		emit({OP_J, 26'(fill)});
		emit('0);
	endtask

endmodule

// ==== sim/tbCpu.sv ====
`timescale 1ns/1ps
`include "mips_cfg.svh"

module tbCpu
	import mipsPkg::*;
();

	logic       clk;
	logic       rstN;
	addr_t      instSramAddr;
	word_t      instSramRdata;
	logic       dataSramEn;
	logic [3:0] dataSramWen;
	addr_t      dataSramAddr;
	word_t      dataSramWdata;
	word_t      dataSramRdata;
	addr_t      debugWbPc;
	logic [3:0] debugWbRfWen;
	regAddr_t   debugWbRfWnum;
	word_t      debugWbRfWdata;
	logic       memFetched;

	// Golden ISA model where pc and npc give the delay slot
	word_t    gpr [32];
	word_t    gmem [256];
	addr_t    pc;
	addr_t    npc;
	addr_t    endPc;
	addr_t    expPc;
	regAddr_t expNum;
	word_t    expData;
	logic     expValid;

	int    errors = 0;
	int    errorsAtStart = 0;
	int    passed = 0;
	int    failed = 0;
	int    testIdx = 0;
	logic  timedOut = 1'b0;
	string testNames [5] = '{"reset and first writeback", "dependent ALU chain",
		"store, load and load-use", "BEQ/BNE with delay slot", "J and register zero"};

	always #10 clk = ~clk;

	mycpuTop dut0 (
		.clk(clk), .rstN_i(rstN),
		.instSramAddr_o(instSramAddr), .instSramRdata_i(instSramRdata),
		.dataSramEn_o(dataSramEn), .dataSramWen_o(dataSramWen),
		.dataSramAddr_o(dataSramAddr), .dataSramWdata_o(dataSramWdata),
		.dataSramRdata_i(dataSramRdata),
		.debugWbPc_o(debugWbPc), .debugWbRfWen_o(debugWbRfWen),
		.debugWbRfWnum_o(debugWbRfWnum), .debugWbRfWdata_o(debugWbRfWdata)
	);

	tbMemory mem0 (
		.clk(clk),
		.instSramAddr_i(instSramAddr), .instSramRdata_o(instSramRdata),
		.dataSramEn_i(dataSramEn), .dataSramWen_i(dataSramWen),
		.dataSramAddr_i(dataSramAddr), .dataSramWdata_i(dataSramWdata),
		.dataSramRdata_o(dataSramRdata), .memFetched_o(memFetched)
	);

	wbMatchesModel: assert property (@(posedge clk) disable iff (!rstN)
		(debugWbRfWen != 4'h0 && expValid) |-> (debugWbPc == expPc &&
			debugWbRfWnum == expNum && debugWbRfWdata == expData))
	else begin
		errors++;
		$display("** Error at %0d ns: writeback pc %h r%0d = %h, model gives pc %h r%0d = %h",
			$time, $sampled(debugWbPc), $sampled(debugWbRfWnum), $sampled(debugWbRfWdata),
			$sampled(expPc), $sampled(expNum), $sampled(expData));
	end

	wbExpected: assert property (@(posedge clk) disable iff (!rstN)
		debugWbRfWen != 4'h0 |-> expValid)
	else begin
		errors++;
		$display("At %0d ns a writeback appeared after the last register write", $time);
	end

	noZeroWrite: assert property (@(posedge clk) disable iff (!rstN)
		debugWbRfWen != 4'h0 |-> debugWbRfWnum != '0)
	else begin
		errors++;
		$display("At %0d ns a write to register zero appeared on the trace port", $time);
	end

	dataIdleBeforeMemOp: assert property (@(posedge clk) disable iff (!rstN)
		(dataSramEn || dataSramWen != 4'h0) |-> memFetched)
	else begin
		errors++;
		$display("At %0d ns the data SRAM was enabled before any LW or SW was fetched", $time);
	end

	task automatic execOne();
		word_t    ins;
		word_t    a;
		word_t    b;
		word_t    immS;
		word_t    res;
		addr_t    ea;
		addr_t    pc4;
		addr_t    target;
		regAddr_t dst;
		logic     wr;
		ins = mem0.imem[pc[9:2]];
		a = gpr[ins[25:21]];
		b = gpr[ins[20:16]];
		immS = {{16{ins[15]}}, ins[15:0]};
		ea = a + immS;
		pc4 = pc + 32'd4;
		target = npc + 32'd4;
		dst = ins[20:16];
		res = '0;
		wr = 1'b1;
		case (ins[31:26])
			OP_SPECIAL: begin
				dst = ins[15:11];
				case (ins[5:0])
					FN_ADDU: res = a + b;
					FN_SUBU: res = a - b;
					FN_AND:  res = a & b;
					FN_OR:   res = a | b;
					FN_XOR:  res = a ^ b;
					FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					FN_SLL:  res = b << ins[10:6];
					default: wr = 1'b0;
				endcase
			end
			OP_ADDIU: res = a + immS;
			OP_ORI:   res = a | {16'h0000, ins[15:0]};
			OP_LUI:   res = {ins[15:0], 16'h0000};
			OP_LW:    res = gmem[ea[9:2]];
			OP_SW: begin
				gmem[ea[9:2]] = b;
				wr = 1'b0;
			end
			OP_BEQ: begin
				wr = 1'b0;
				if (a == b) begin
					target = pc4 + (immS << 2);
				end
			end
			OP_BNE: begin
				wr = 1'b0;
				if (a != b) begin
					target = pc4 + (immS << 2);
				end
			end
			OP_J: begin
				wr = 1'b0;
				target = {pc4[31:28], ins[25:0], 2'b00};
			end
			default: wr = 1'b0;
		endcase
		if (wr && dst != '0) begin
			gpr[dst] = res;
			expPc = pc;
			expNum = dst;
			expData = res;
			expValid = 1'b1;
		end
		pc = npc;
		npc = target;
	endtask

	// Runs the model up to and including the next instruction that writes a register
	task automatic nextWriter();
		int steps;
		steps = 0;
		expValid = 1'b0;
		while (!expValid && pc != endPc && steps < 1024) begin
			execOne();
			steps++;
		end
	endtask

	task automatic waitWriteback(output logic late);
		int cycles;
		cycles = 0;
		while (debugWbRfWen == 4'h0 && cycles < 200) begin
			@(negedge clk);
			cycles++;
		end
		late = (debugWbRfWen == 4'h0);
	endtask

	// Stores land at the addresses the model computed
	task automatic checkMemory();
		foreach (gmem[i]) begin
			assert (mem0.dmem[i] == gmem[i])
			else begin
				errors++;
				$display("** Error at %0d ns: data word %0d holds %h, model gives %h",
					$time, i, mem0.dmem[i], gmem[i]);
			end
		end
	endtask

	task automatic closeTests(addr_t reached);
		while (testIdx < 5 && reached >= addr_t'(mem0.segEnd[testIdx])) begin
			if (errors == errorsAtStart) begin
				passed++;
				$display("test %0d %s: passed", testIdx + 1, testNames[testIdx]);
			end else begin
				failed++;
				$display("test %0d %s: failed with %0d errors", testIdx + 1,
					testNames[testIdx], errors - errorsAtStart);
			end
			errorsAtStart = errors;
			testIdx++;
		end
	endtask

	initial begin
		clk = 1'b0;
		rstN = 1'b0;
		void'($urandom(32'h4e53));
		mem0.buildProgram();
		foreach (gpr[i]) begin
			gpr[i] = '0;
		end
		foreach (gmem[i]) begin
			gmem[i] = mem0.dmem[i];
		end
		pc = `RESET_PC;
		npc = `RESET_PC + 32'd4;
		endPc = addr_t'(mem0.segEnd[4]);
		nextWriter();
		repeat (8) @(posedge clk);
		rstN <= 1'b1;
		@(negedge clk);
		while (expValid && !timedOut) begin
			waitWriteback(timedOut);
			if (!timedOut) begin
				// The posedge in between has compared this writeback
				@(negedge clk);
				nextWriter();
				closeTests(expValid ? expPc : pc);
			end
		end
		if (timedOut) begin
			$display("no writeback seen before timeout");
		end else begin
			repeat (20) @(negedge clk);
			checkMemory();
		end
		while (testIdx < 5) begin
			failed++;
			$display("test %0d %s: did not finish", testIdx + 1, testNames[testIdx]);
			testIdx++;
		end
		$display("%0d tests passed, %0d failed, %0d errors", passed, failed, errors);
		if (!timedOut && errors == 0 && failed == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

// ==== sim.f ====
+incdir+src
src/mipsPkg.sv
src/regFile.sv
src/fetchStage.sv
src/decodeStage.sv
src/executeStage.sv
src/memoryStage.sv
src/hazardUnit.sv
src/mycpuTop.sv
sim/tbMemory.sv
sim/tbCpu.sv

// ==== Bender.yml ====
package:
  name: mycpu

sources:
  - include_dirs:
      - src
    files:
      - src/mipsPkg.sv
      - src/regFile.sv
      - src/fetchStage.sv
      - src/decodeStage.sv
      - src/executeStage.sv
      - src/memoryStage.sv
      - src/hazardUnit.sv
      - src/mycpuTop.sv
  - target: test
    include_dirs:
      - src
    files:
      - sim/tbMemory.sv
      - sim/tbCpu.sv
